// File: timer_params.svh
`ifndef TIMER_PARAMS_SVH
`define TIMER_PARAMS_SVH

// ==============================
// Time base
// ==============================

// Clock cycles per displayed second, kept small for simulation
`define TICKS_PER_SECOND 16

// Cycles each display digit stays selected
`define SCAN_CYCLES 4

// ==============================
// Round lengths and LED bar
// ==============================

`define DUR_0 65    // sw[0]
`define DUR_1 85    // sw[1]
`define DUR_2 105   // sw[2]
`define DUR_3 125   // sw[3]

`define LED_COUNT 16

// ==============================
// Point tables
// ==============================

`define POINTS_EASY   4
`define POINTS_MEDIUM 8
`define POINTS_HARD   12

`define PENALTY_EASY   1   // Per deduction
`define PENALTY_MEDIUM 2
`define PENALTY_HARD   3

`endif

// File: timer_pkg.sv
`default_nettype none

`include "timer_params.svh"

package timer_pkg;

    // ==============================
    // Plain widths
    // ==============================

    typedef logic [7:0]            seconds_t;    // Round time in seconds
    typedef logic [`LED_COUNT-1:0] led_bar_t;    // One bit per LED
    typedef logic [13:0]           points_t;     // Score, up to 9999 shown
    typedef logic [2:0]            deduction_t;  // 0 to 4
    typedef logic [3:0]            digit_t;      // One decimal digit
    typedef logic [7:0]            seg_t;        // Active low, dp in bit 7
    typedef logic [3:0]            anode_t;      // Active low digit enables

    // Round FSM
    typedef enum logic {
        ROUND_IDLE,
        ROUND_RUNNING
    } round_state_t;

    // ==============================
    // Bundles between blocks
    // ==============================

    typedef struct packed {
        logic     valid;     // Exactly one duration switch on
        seconds_t seconds;   // Zero when not valid
    } round_cfg_t;

    typedef struct packed {
        logic       done;       // One cycle at round end
        deduction_t deduction;  // Held until next start
    } round_result_t;

    typedef struct packed {
        points_t p1;
        points_t p2;
    } player_scores_t;

    typedef struct packed {
        anode_t an;
        seg_t   seg;
    } seg_drive_t;

endpackage

`default_nettype wire

// File: duration_select.sv
`default_nettype none

`include "timer_params.svh"

module duration_select (
    input  wire                        clk,
    input  wire                        reset,
    input  wire [3:0]                  sw_duration,  // sw[3:0], one-hot
    output timer_pkg::round_cfg_t      cfg
);

    timer_pkg::round_cfg_t cfg_next;

    // One-hot decode of the duration switches
    always_comb begin
        case (sw_duration)
            4'b0001: cfg_next = '{valid: 1'b1, seconds: timer_pkg::seconds_t'(`DUR_0)};
            4'b0010: cfg_next = '{valid: 1'b1, seconds: timer_pkg::seconds_t'(`DUR_1)};
            4'b0100: cfg_next = '{valid: 1'b1, seconds: timer_pkg::seconds_t'(`DUR_2)};
            4'b1000: cfg_next = '{valid: 1'b1, seconds: timer_pkg::seconds_t'(`DUR_3)};
            default: cfg_next = '{valid: 1'b0, seconds: '0};  // None or several on
        endcase
    end

    // Registered config, one cycle behind the switches
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg <= '0;
        end else begin
            cfg <= cfg_next;
        end
    end

    // ==============================
    // Checks
    // ==============================

    // Invalid selection must never carry a length into the timer or display
    a_invalid_zero: assert property (
        @(posedge clk) disable iff (reset)
        !cfg.valid |-> (cfg.seconds == '0)
    );

endmodule

`default_nettype wire

// File: countdown_bar.sv
`default_nettype none

`include "timer_params.svh"

module countdown_bar (
    input  wire                          clk,
    input  wire                          reset,
    input  wire                          game_start,    // Rising edge starts a round
    input  wire                          word_correct,  // Ends the round early
    input  wire timer_pkg::round_cfg_t   cfg,
    output timer_pkg::led_bar_t          led,
    output timer_pkg::seconds_t          seconds_left,
    output timer_pkg::round_result_t     result
);

    localparam int STEP_W = 24;
    localparam int SEC_W  = $clog2(`TICKS_PER_SECOND + 1);
    localparam int IDX_W  = $clog2(`LED_COUNT);

    timer_pkg::round_state_t state;
    logic                    start_d;     // game_start, one cycle old
    logic                    start_edge;
    logic [STEP_W-1:0]       step_len;    // Cycles per LED, captured at start
    logic [STEP_W-1:0]       step_cnt;
    logic                    step_end;
    logic [IDX_W-1:0]        dark_idx;    // Next LED to go dark
    logic                    last_step;
    logic                    ded_point;
    logic [SEC_W-1:0]        sec_cnt;
    logic                    sec_end;
    timer_pkg::deduction_t   deduction;
    logic                    done;

    assign start_edge = game_start && !start_d;
    assign step_end   = (step_cnt == step_len - STEP_W'(1));
    assign sec_end    = (sec_cnt == SEC_W'(`TICKS_PER_SECOND - 1));
    assign last_step  = (dark_idx == IDX_W'(`LED_COUNT - 1));

    // Deduction when the index leaves 4, 8, 12 or 15
    assign ded_point = (dark_idx == IDX_W'(4))
                    || (dark_idx == IDX_W'(8))
                    || (dark_idx == IDX_W'(12))
                    || last_step;

    assign result = '{done: done, deduction: deduction};

    // Start edge detect
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            start_d <= 1'b0;
        end else begin
            start_d <= game_start;
        end
    end

    // ==============================
    // Round FSM and counters
    // ==============================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= timer_pkg::ROUND_IDLE;
            led          <= '0;
            seconds_left <= '0;
            deduction    <= '0;
            done         <= 1'b0;
            dark_idx     <= '0;
            step_len     <= '0;
            step_cnt     <= '0;
            sec_cnt      <= '0;
        end else begin
            done <= 1'b0;  // Pulse unless set below
            case (state)
                timer_pkg::ROUND_IDLE: begin
                    if (start_edge && cfg.valid) begin  // Invalid config ignores start
                        state        <= timer_pkg::ROUND_RUNNING;
                        led          <= '1;             // Full bar
                        seconds_left <= cfg.seconds;
                        deduction    <= '0;
                        dark_idx     <= '0;
                        step_cnt     <= '0;
                        sec_cnt      <= '0;
                        step_len     <= STEP_W'((32'(cfg.seconds) * `TICKS_PER_SECOND)
                                                / `LED_COUNT);
                    end
                end

                timer_pkg::ROUND_RUNNING: begin
                    if (word_correct) begin
                        // Solved, end now and keep the tally
                        state        <= timer_pkg::ROUND_IDLE;
                        done         <= 1'b1;
                        led          <= '0;
                        seconds_left <= '0;
                    end else begin
                        // Seconds readout
                        if (sec_end) begin
                            sec_cnt <= '0;
                            if (seconds_left != '0) begin
                                seconds_left <= seconds_left - 1'b1;
                            end
                        end else begin
                            sec_cnt <= sec_cnt + 1'b1;
                        end

                        // LED steps, bit 0 first
                        if (step_end) begin
                            step_cnt      <= '0;
                            led[dark_idx] <= 1'b0;
                            dark_idx      <= dark_idx + 1'b1;
                            if (ded_point) begin
                                deduction <= deduction + 1'b1;
                            end
                            if (last_step) begin  // Time ran out
                                state        <= timer_pkg::ROUND_IDLE;
                                done         <= 1'b1;
                                led          <= '0;
                                seconds_left <= '0;
                            end
                        end else begin
                            step_cnt <= step_cnt + 1'b1;
                        end
                    end
                end

                default: state <= timer_pkg::ROUND_IDLE;
            endcase
        end
    end

    // ==============================
    // Checks
    // ==============================

    a_done_pulse: assert property (
        @(posedge clk) disable iff (reset)
        result.done |=> !result.done
    );

    a_ded_max: assert property (
        @(posedge clk) disable iff (reset)
        result.deduction <= 3'd4
    );

    a_idle_dark: assert property (
        @(posedge clk) disable iff (reset)
        (state == timer_pkg::ROUND_IDLE) |-> (led == '0)
    );

endmodule

`default_nettype wire

// File: score_keeper.sv
`default_nettype none

`include "timer_params.svh"

module score_keeper (
    input  wire                           clk,
    input  wire                           reset,
    input  wire [2:0]                     sw_difficulty,  // sw[14:12]
    input  wire [1:0]                     sw_player,      // sw[11:10]
    input  wire                           sw_clear,       // sw[15]
    input  wire timer_pkg::round_result_t result,
    output timer_pkg::player_scores_t     scores
);

    timer_pkg::points_t points;      // This round's award
    logic               sel_p2;
    logic               clear_d;
    logic               clear_edge;

    // ==============================
    // Round points
    // ==============================

    // Base minus penalty per deduction; bad pattern gives nothing
    always_comb begin
        case (sw_difficulty)
            3'b100: points = timer_pkg::points_t'(`POINTS_EASY)
                           - timer_pkg::points_t'(result.deduction * `PENALTY_EASY);
            3'b010: points = timer_pkg::points_t'(`POINTS_MEDIUM)
                           - timer_pkg::points_t'(result.deduction * `PENALTY_MEDIUM);
            3'b001: points = timer_pkg::points_t'(`POINTS_HARD)
                           - timer_pkg::points_t'(result.deduction * `PENALTY_HARD);
            default: points = '0;
        endcase
    end

    // sw[11] wins, then sw[10], else player 1
    assign sel_p2 = !sw_player[1] && sw_player[0];

    assign clear_edge = sw_clear && !clear_d;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            clear_d <= 1'b0;
        end else begin
            clear_d <= sw_clear;
        end
    end

    // ==============================
    // Accumulators
    // ==============================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            scores <= '0;
        end else if (clear_edge) begin  // Clear beats an award
            scores <= '0;
        end else if (result.done) begin
            if (sel_p2) begin
                scores.p2 <= scores.p2 + points;
            end else begin
                scores.p1 <= scores.p1 + points;
            end
        end
    end

    // Scores move only after a round end or a clear edge
    a_score_hold: assert property (
        @(posedge clk) disable iff (reset)
        !$stable(scores) |-> ($past(result.done) || $past(clear_edge))
    );

endmodule

`default_nettype wire

// File: score_display.sv
`default_nettype none

`include "timer_params.svh"

module score_display (
    input  wire                            clk,
    input  wire                            reset,
    input  wire [2:0]                      sw_view,       // sw[11:9]
    input  wire timer_pkg::round_cfg_t     cfg,
    input  wire timer_pkg::seconds_t       seconds_left,
    input  wire timer_pkg::player_scores_t scores,
    output timer_pkg::seg_drive_t          drive
);

    localparam int              SCAN_W  = $clog2(`SCAN_CYCLES + 1);
    localparam timer_pkg::seg_t SEG_OFF = 8'b1111_1111;

    timer_pkg::points_t shown;        // Value picked for display
    logic               blank;
    logic               blank_q;
    timer_pkg::digit_t  digits [4];   // [0] ones .. [3] thousands
    logic [3:0]         lit;          // Digit visible after zero blanking
    logic [SCAN_W-1:0]  scan_cnt;
    logic [1:0]         pos;          // Digit being driven

    // Active low patterns, segment a in bit 0
    function automatic timer_pkg::seg_t encode(input timer_pkg::digit_t d);
        case (d)
            4'd0:    return 8'b1100_0000;
            4'd1:    return 8'b1111_1001;
            4'd2:    return 8'b1010_0100;
            4'd3:    return 8'b1011_0000;
            4'd4:    return 8'b1001_1001;
            4'd5:    return 8'b1001_0010;
            4'd6:    return 8'b1000_0010;
            4'd7:    return 8'b1111_1000;
            4'd8:    return 8'b1000_0000;
            4'd9:    return 8'b1001_0000;
            default: return SEG_OFF;
        endcase
    endfunction

    // ==============================
    // View select
    // ==============================

    always_comb begin
        blank = 1'b0;
        shown = timer_pkg::points_t'(seconds_left);  // Default time view
        if (sw_view[0]) begin
            if (sw_view[2]) begin
                shown = scores.p1;
            end else if (sw_view[1]) begin
                shown = scores.p2;
            end else begin
                shown = scores.p1;  // No player picked
            end
        end else if (!cfg.valid) begin
            blank = 1'b1;           // Bad duration switches
            shown = '0;
        end
    end

    // Binary to decimal, one cycle behind the view
    always_ff @(posedge clk) begin
        digits[0] <= timer_pkg::digit_t'(shown % 10);
        digits[1] <= timer_pkg::digit_t'((shown / 10) % 10);
        digits[2] <= timer_pkg::digit_t'((shown / 100) % 10);
        digits[3] <= timer_pkg::digit_t'((shown / 1000) % 10);
    end

    // Leading zero suppression, ones always lit unless blank
    assign lit[0] = !blank_q;
    assign lit[1] = !blank_q && ((digits[3] != '0) || (digits[2] != '0)
                                 || (digits[1] != '0));
    assign lit[2] = !blank_q && ((digits[3] != '0) || (digits[2] != '0));
    assign lit[3] = !blank_q && (digits[3] != '0);

    // ==============================
    // Digit scan
    // ==============================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            blank_q  <= 1'b1;
            scan_cnt <= '0;
            pos      <= '0;                 // Ones first
            drive    <= '{an: 4'b1111, seg: SEG_OFF};
        end else begin
            blank_q <= blank;
            if (scan_cnt == SCAN_W'(`SCAN_CYCLES - 1)) begin
                scan_cnt  <= '0;
                pos       <= pos + 1'b1;    // Move one digit left
                drive.an  <= blank_q ? 4'b1111 : ~(4'b0001 << pos);  // No digit when blank
                drive.seg <= lit[pos] ? encode(digits[pos]) : SEG_OFF;
            end else begin
                scan_cnt <= scan_cnt + 1'b1;
            end
        end
    end

    // Never two digits driven at once
    a_one_anode: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(~drive.an)
    );

endmodule

`default_nettype wire

// File: led_timer_score.sv
`default_nettype none

module led_timer_score (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 game_start,
    input  wire                 word_correct,
    input  wire [15:0]          sw,
    output timer_pkg::led_bar_t led,
    output timer_pkg::anode_t   an,
    output timer_pkg::seg_t     seg,
    output logic                timer_done
);

    timer_pkg::round_cfg_t      cfg;
    timer_pkg::round_result_t   result;
    timer_pkg::seconds_t        seconds_left;
    timer_pkg::player_scores_t  scores;
    timer_pkg::seg_drive_t      drive;

    // ==============================
    // Blocks
    // ==============================

    duration_select u_duration_select (
        .clk         (clk),
        .reset       (reset),
        .sw_duration (sw[3:0]),
        .cfg         (cfg)
    );

    countdown_bar u_countdown_bar (
        .clk          (clk),
        .reset        (reset),
        .game_start   (game_start),
        .word_correct (word_correct),
        .cfg          (cfg),
        .led          (led),
        .seconds_left (seconds_left),
        .result       (result)
    );

    score_keeper u_score_keeper (
        .clk           (clk),
        .reset         (reset),
        .sw_difficulty (sw[14:12]),
        .sw_player     (sw[11:10]),
        .sw_clear      (sw[15]),
        .result        (result),
        .scores        (scores)
    );

    score_display u_score_display (
        .clk          (clk),
        .reset        (reset),
        .sw_view      (sw[11:9]),     // Player picks plus score view
        .cfg          (cfg),
        .seconds_left (seconds_left),
        .scores       (scores),
        .drive        (drive)
    );

    assign an         = drive.an;
    assign seg        = drive.seg;
    assign timer_done = result.done;  // Timeout or solve

endmodule

`default_nettype wire

// File: tb_led_timer_score.sv
`default_nettype none

`include "timer_params.svh"

module tb_led_timer_score;

    // Twice the total round time of the run, plus room for the score reads
    localparam int RUN_SECONDS   = `DUR_0 + `DUR_1 + `DUR_2 + `DUR_3 + 8 * `DUR_3;
    localparam int WATCHDOG_TIME = RUN_SECONDS * `TICKS_PER_SECOND * 40 * 2 + 200000;
    localparam timer_pkg::seg_t BLANK_SEG = 8'hFF;

    logic                clk;
    logic                reset;
    logic                game_start;
    logic                word_correct;
    logic [15:0]         sw;
    timer_pkg::led_bar_t led;
    timer_pkg::anode_t   an;
    timer_pkg::seg_t     seg;
    logic                timer_done;

    int                  errors = 0;
    integer              seed   = 32'had78;
    timer_pkg::points_t  p1_sum;        // Expected totals per player
    timer_pkg::points_t  p2_sum;

    led_timer_score DUT (
        .clk          (clk),
        .reset        (reset),
        .game_start   (game_start),
        .word_correct (word_correct),
        .sw           (sw),
        .led          (led),
        .an           (an),
        .seg          (seg),
        .timer_done   (timer_done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ==============================
    // Reference model
    // ==============================

    function automatic int dur_of(input int idx);
        case (idx)
            0:       return `DUR_0;
            1:       return `DUR_1;
            2:       return `DUR_2;
            default: return `DUR_3;
        endcase
    endfunction

    // Three valid one-hot levels, then a bad pattern
    function automatic logic [2:0] pick_difficulty(input int n);
        case (n)
            0:       return 3'b100;
            1:       return 3'b010;
            2:       return 3'b001;
            default: return 3'b011;
        endcase
    endfunction

    // Base minus penalty for each of LEDs 5, 9, 13, 16 gone dark
    function automatic timer_pkg::points_t expected_points(input logic [2:0] difficulty,
                                                           input int leds_dark);
        int ded;
        int base;
        int penalty;
        ded = int'(leds_dark >= 5) + int'(leds_dark >= 9) + int'(leds_dark >= 13)
            + int'(leds_dark >= 16);
        base    = 0;
        penalty = 0;
        case (difficulty)
            3'b100: begin
                base    = `POINTS_EASY;
                penalty = `PENALTY_EASY;
            end
            3'b010: begin
                base    = `POINTS_MEDIUM;
                penalty = `PENALTY_MEDIUM;
            end
            3'b001: begin
                base    = `POINTS_HARD;
                penalty = `PENALTY_HARD;
            end
            default: ;                      // Bad pattern scores nothing
        endcase
        return timer_pkg::points_t'(base - ded * penalty);
    endfunction

    // Active low digit patterns of the board
    function automatic timer_pkg::seg_t seg_code(input int d);
        case (d)
            0:       return 8'b1100_0000;
            1:       return 8'b1111_1001;
            2:       return 8'b1010_0100;
            3:       return 8'b1011_0000;
            4:       return 8'b1001_1001;
            5:       return 8'b1001_0010;
            6:       return 8'b1000_0010;
            7:       return 8'b1111_1000;
            8:       return 8'b1000_0000;
            default: return 8'b1001_0000;
        endcase
    endfunction

    // Expected pattern for one digit position, with leading zeros dark
    function automatic timer_pkg::seg_t display_pattern(input int value, input int pos);
        int scale;
        scale = 1;
        repeat (pos) scale = scale * 10;
        if (pos > 0 && value < scale) begin
            return BLANK_SEG;
        end
        return seg_code((value / scale) % 10);
    endfunction

    function automatic int seg_digit(input timer_pkg::seg_t s);
        int d;
        for (d = 0; d < 10; d++) begin
            if (seg_code(d) == s) return d;
        end
        return 0;                           // Dark digit counts as zero
    endfunction

    function automatic int anode_pos(input timer_pkg::anode_t a);
        case (a)
            4'b1110: return 0;              // Ones
            4'b1101: return 1;
            4'b1011: return 2;
            4'b0111: return 3;
            default: return -1;
        endcase
    endfunction

    // ==============================
    // Checks
    // ==============================

    task automatic report_failure();
        errors++;
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_points(input string name, input timer_pkg::points_t expected,
                                input timer_pkg::points_t actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_led(input string name, input timer_pkg::led_bar_t expected,
                             input timer_pkg::led_bar_t actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_seg(input string name, input timer_pkg::seg_t expected,
                             input timer_pkg::seg_t actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            report_failure();
        end
    endtask

    task automatic check_an(input string name, input timer_pkg::anode_t expected,
                            input timer_pkg::anode_t actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
            report_failure();
        end
    endtask

    // ==============================
    // Stimulus helpers
    // ==============================

    task automatic next_cycle();
        @(posedge clk);
        #5;                                 // Inputs move just after the edge
    endtask

    // Let the scan settle, then watch one full rotation and compare each digit
    task automatic check_shown(input int expected, input bit blank);
        timer_pkg::seg_t   segs [4];
        timer_pkg::anode_t prev_an;
        int                i;
        int                pos;
        int                value;
        int                scale;
        repeat (8 * `SCAN_CYCLES) next_cycle();
        prev_an = an;
        for (i = 0; i < 4 * `SCAN_CYCLES; i++) begin
            next_cycle();
            if (blank) begin
                check_an("an", 4'b1111, an);    // Dark display selects no digit
                check_seg("seg", BLANK_SEG, seg);
            end
            pos = anode_pos(an);
            if (an != prev_an && pos >= 0) segs[pos] = seg;
            prev_an = an;
        end
        if (!blank) begin
            value = 0;
            scale = 1;
            for (i = 0; i < 4; i++) begin
                value = value + seg_digit(segs[i]) * scale;
                scale = scale * 10;
            end
            check_points("shown score", timer_pkg::points_t'(expected),
                         timer_pkg::points_t'(value));
            // Digits right, now the blanking of leading zeros
            for (i = 0; i < 4; i++) begin
                check_seg("seg", display_pattern(expected, i), segs[i]);
            end
        end
    endtask

    task automatic check_score(input int player, input timer_pkg::points_t expected);
        sw[9]  = 1'b1;                      // Score view
        sw[10] = (player == 2);
        sw[11] = (player == 1);
        check_shown(int'(expected), 1'b0);
        sw[9]  = 1'b0;
    endtask

    task automatic set_switches(input int idx, input logic [2:0] diff, input int player);
        sw[3:0]   = 4'(1 << idx);
        sw[9]     = 1'b0;
        sw[10]    = (player == 2);
        sw[11]    = (player == 1);
        sw[14:12] = diff;
        repeat (2) next_cycle();            // Config is registered
    endtask

    // Start with a bad duration pattern must be ignored
    task automatic start_ignored(input logic [3:0] pattern);
        int i;
        sw[3:0] = pattern;
        sw[9]   = 1'b0;
        repeat (2) next_cycle();
        game_start = 1'b1;
        for (i = 0; i < 48; i++) begin
            next_cycle();
            game_start = 1'b0;
            check_led("led", '0, led);
            if (timer_done) begin
                $display("timer_done pulsed after a start with invalid duration switches");
                report_failure();
            end
        end
        check_shown(0, 1'b1);               // Display dark
    endtask

    // One round; solve_k < 0 lets the time run out
    task automatic run_round(input int dur, input int solve_k, output int dark);
        timer_pkg::anode_t prev_an;
        int                k;
        int                limit;
        int                rem;
        int                pos;
        int                done_at;
        limit = dur * `TICKS_PER_SECOND;
        check_led("led", '0, led);          // Idle bar
        game_start = 1'b1;
        next_cycle();
        game_start = 1'b0;
        k          = 0;
        prev_an    = an;
        while (!timer_done) begin
            if (k >= limit) begin
                $display("timer_done missing %0d cycles into the round", k);
                report_failure();
            end
            check_led("led", timer_pkg::led_bar_t'(16'hFFFF << (k / dur)), led);
            // Time view, display lags the counter by up to one second
            pos = anode_pos(an);
            rem = dur - k / `TICKS_PER_SECOND;
            if (k >= 2 && an != prev_an && pos >= 0
                && seg != display_pattern(rem + 1, pos)) begin
                check_seg("seg", display_pattern(rem, pos), seg);
            end
            prev_an      = an;
            word_correct = (k == solve_k);
            next_cycle();
            k++;
        end
        word_correct = 1'b0;
        done_at = (solve_k < 0) ? limit : solve_k + 1;
        if (k != done_at) begin
            $display("** Error timer_done cycle: expected %h, actual %h", done_at, k);
            report_failure();
        end
        check_led("led", '0, led);
        dark = (solve_k < 0) ? 16 : solve_k / dur;
        next_cycle();                       // Score lands here
        if (timer_done) begin
            $display("timer_done stayed high for more than one cycle");
            report_failure();
        end
    endtask

    // Play a round, update the expected totals, read both scores back
    task automatic play_round(input int idx, input logic [2:0] diff, input int player,
                              input int step);
        timer_pkg::points_t pts;
        int                 dur;
        int                 dark;
        int                 solve_k;
        dur     = dur_of(idx);
        solve_k = (step < 0) ? -1 : step * dur + dur / 2;  // Middle of the step
        set_switches(idx, diff, player);
        run_round(dur, solve_k, dark);
        pts = expected_points(diff, dark);
        if (player == 2) begin
            p2_sum = p2_sum + pts;
        end else begin
            p1_sum = p1_sum + pts;
        end
        check_score(1, p1_sum);
        check_score(2, p2_sum);
    endtask

    // ==============================
    // Test sequence
    // ==============================

    initial begin
        int         i;
        int         idx;
        int         step;
        logic [2:0] diff;
        reset        = 1'b1;
        game_start   = 1'b0;
        word_correct = 1'b0;
        sw           = '0;
        p1_sum       = '0;
        p2_sum       = '0;
        repeat (8) next_cycle();
        reset = 1'b0;
        next_cycle();
        check_led("led", '0, led);
        if (timer_done) begin
            $display("timer_done high right after reset");
            report_failure();
        end
        check_score(1, p1_sum);
        check_score(2, p2_sum);

        start_ignored(4'b0000);             // No duration
        start_ignored(4'b0011);             // Two durations

        // Full timeouts, zero points at any level
        for (i = 0; i < 4; i++) begin
            play_round(i, pick_difficulty(i % 3), 1, -1);
        end

        // Random early solves, players alternate
        for (i = 0; i < 6; i++) begin
            idx  = $unsigned($random(seed)) % 4;
            diff = pick_difficulty($unsigned($random(seed)) % 4);
            if (i == 5) begin
                diff = pick_difficulty(3);  // At least one solve on a bad level
            end
            step = $unsigned($random(seed)) % 16;
            play_round(idx, diff, (i % 2) + 1, step);
        end

        // Clear on sw[15] edge, held level leaves awards alone
        sw[15] = 1'b1;
        next_cycle();
        p1_sum = '0;
        p2_sum = '0;
        check_score(1, p1_sum);
        check_score(2, p2_sum);
        play_round(0, 3'b001, 2, 2);
        sw[15] = 1'b0;
        next_cycle();
        sw[15] = 1'b1;
        next_cycle();
        p1_sum = '0;
        p2_sum = '0;
        check_score(1, p1_sum);
        check_score(2, p2_sum);
        sw[15] = 1'b0;
        play_round(1, 3'b010, 1, 6);

        if (errors == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            report_failure();
        end
    end

    // Hang guard
    initial begin
        #(WATCHDOG_TIME);
        $display("Watchdog expired before the test sequence finished");
        report_failure();
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
timer_pkg.sv
duration_select.sv
countdown_bar.sv
score_keeper.sv
score_display.sv
led_timer_score.sv
tb_led_timer_score.sv
